// ==== comp_engine_pkg.sv ====
`default_nettype none

package comp_engine_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    typedef logic [31:0] addr_t;
    typedef logic [31:0] bus_word_t;
    typedef logic [63:0] comp_word_t;
    // block address bits 31..7
    typedef logic [24:0] blk_cnt_t;
    typedef logic [3:0]  beat_idx_t;
    typedef logic [2:0]  buf_addr_t;
    typedef logic [1:0]  comp_sel_t;
    typedef logic [1:0]  htrans_t;

    // ------------------------------
    // AHB encodings
    // ------------------------------
    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;
    localparam htrans_t HTRANS_SEQ    = 2'b11;

    // fixed on this bus, never driven as ports
    localparam logic [2:0] HSIZE_WORD    = 3'b010;
    localparam logic [2:0] HBURST_INCR16 = 3'b111;
    localparam logic [3:0] HPROT_DATA    = 4'b0001;

    // burst geometry
    localparam int BEATS_PER_BURST     = 16;
    localparam int BEAT_BYTES          = 4;
    localparam int BLK_RD_BYTES        = 128;
    localparam int BLK_WR_BYTES        = 64;
    localparam int NUM_COMP            = 3;
    // request drops after this read data beat
    localparam int BUSREQ_RELEASE_BEAT = 13;

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD1,
        S_RD2,
        S_COMP,
        S_WR
    } seq_state_t;

endpackage

`default_nettype wire

// ==== burst_if.sv ====
`default_nettype none

interface burst_if
    import comp_engine_pkg::*;
(
    input wire clk
);

    // sequencer to master
    logic       go;
    logic       wr;
    addr_t      base_addr;
    comp_word_t wr_word;

    // master back to sequencer and packer
    logic       fin;
    logic       beat_vld;
    beat_idx_t  beat_idx;
    bus_word_t  rdata;

    modport seq (
        input  clk,
        output go,
        output wr,
        output base_addr,
        output wr_word,
        input  fin
    );

    modport mst (
        input  clk,
        input  go,
        input  wr,
        input  base_addr,
        input  wr_word,
        output fin,
        output beat_vld,
        output beat_idx,
        output rdata
    );

    // read beats only
    modport sink (
        input  clk,
        input  beat_vld,
        input  beat_idx,
        input  rdata
    );

endinterface

`default_nettype wire

// ==== blk_sequencer.sv ====
`default_nettype none

module blk_sequencer
    import comp_engine_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst_n,

    input  wire addr_t              src_addr_i,
    input  wire addr_t              dst_addr_i,
    input  wire blk_cnt_t           len_i,
    input  wire                     start_i,
    output logic                    done_o,

    input  wire [NUM_COMP-1:0]      comp_done_i,
    input  wire [NUM_COMP-1:0]      comp_fail_i,
    input  wire comp_word_t         comp0_rdata_i,
    input  wire comp_word_t         comp1_rdata_i,
    input  wire comp_word_t         comp2_rdata_i,

    burst_if.seq                    bus
);

    seq_state_t state_q;
    blk_cnt_t   blk_cnt_q;
    blk_cnt_t   blk_cnt_inc;
    comp_sel_t  winner_q;
    comp_sel_t  pick;
    logic       go_q;
    logic       all_done;
    addr_t      rd_base;
    addr_t      wr_base;
    addr_t      base_addr;
    comp_word_t wr_word;

    assign all_done    = &comp_done_i;
    assign blk_cnt_inc = blk_cnt_q + blk_cnt_t'(1);

    // ------------------------------
    // block addresses
    // ------------------------------
    assign rd_base = src_addr_i + addr_t'(blk_cnt_q) * addr_t'(BLK_RD_BYTES);
    assign wr_base = dst_addr_i + addr_t'(blk_cnt_q) * addr_t'(BLK_WR_BYTES);

    always_comb begin
        case (state_q)
            // second read burst picks up the upper 64 bytes
            S_RD2: base_addr = rd_base + addr_t'(BEATS_PER_BURST * BEAT_BYTES);
            S_WR: base_addr = wr_base;
            default: base_addr = rd_base;
        endcase
    end

    // ------------------------------
    // compressor winner
    // ------------------------------
    // lowest non-failing one, 0 when all fail
    always_comb begin
        pick = '0;
        for (int k = NUM_COMP - 1; k >= 0; k--) begin
            if (!comp_fail_i[k]) begin
                pick = comp_sel_t'(k);
            end
        end
    end

    // buffer word already addressed by buf_addr_o
    always_comb begin
        case (winner_q)
            2'd1: wr_word = comp1_rdata_i;
            2'd2: wr_word = comp2_rdata_i;
            default: wr_word = comp0_rdata_i;
        endcase
    end

    // ------------------------------
    // block loop
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= S_IDLE;
            blk_cnt_q <= '0;
            winner_q  <= '0;
            go_q      <= 1'b0;
        end else begin
            // go is a single-cycle strobe
            go_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (start_i && (len_i != '0)) begin
                        blk_cnt_q <= '0;
                        state_q   <= S_RD1;
                        go_q      <= 1'b1;
                    end
                end
                S_RD1: begin
                    if (bus.fin) begin
                        state_q <= S_RD2;
                        go_q    <= 1'b1;
                    end
                end
                S_RD2: begin
                    if (bus.fin) begin
                        state_q <= S_COMP;
                    end
                end
                S_COMP: begin
                    if (all_done) begin
                        winner_q <= pick;
                        state_q  <= S_WR;
                        go_q     <= 1'b1;
                    end
                end
                S_WR: begin
                    if (bus.fin) begin
                        blk_cnt_q <= blk_cnt_inc;
                        if (blk_cnt_inc == len_i) begin
                            state_q <= S_IDLE;
                        end else begin
                            state_q <= S_RD1;
                            go_q    <= 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    assign bus.go        = go_q;
    assign bus.wr        = (state_q == S_WR);
    assign bus.base_addr = base_addr;
    assign bus.wr_word   = wr_word;

    // masked while start is high so a status poll never sees a stale done
    assign done_o = (state_q == S_IDLE) && !start_i;

endmodule

`default_nettype wire

// ==== ahb_burst_master.sv ====
`default_nettype none

module ahb_burst_master
    import comp_engine_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst_n,

    output logic                    hbusreq_o,
    input  wire                     hgrant_i,
    output addr_t                   haddr_o,
    output htrans_t                 htrans_o,
    output logic                    hwrite_o,
    output bus_word_t               hwdata_o,
    input  wire bus_word_t          hrdata_i,
    input  wire                     hready_i,

    output buf_addr_t               buf_addr_o,

    burst_if.mst                    bus
);

    // ------------------------------
    // burst phases
    // ------------------------------
    // address: | 0 | 1 | 2 | ... |14 |15 |
    // data   :     | 0 | 1 | ... |13 |14 |15 |
    //          ADDR1 |      MIDDLE       | LAST
    typedef enum logic [2:0] {
        M_IDLE,
        M_BUSREQ,
        M_ADDR1,
        M_MIDDLE,
        M_LAST
    } mst_state_t;

    mst_state_t state_q;
    // index of the address phase on the bus
    beat_idx_t  abeat_q;
    beat_idx_t  dbeat;
    beat_idx_t  beat_idx;
    bus_word_t  wr_half;
    logic       fin_q;
    logic       addr_acc;
    logic       data_phase;

    // data lags address by one accepted phase
    assign dbeat      = abeat_q - beat_idx_t'(1);
    assign data_phase = (state_q == M_MIDDLE) || (state_q == M_LAST);
    assign addr_acc   = hready_i && ((state_q == M_ADDR1) || (state_q == M_MIDDLE));

    // writes follow the address being issued, reads the data returned
    assign beat_idx   = hwrite_o ? abeat_q : dbeat;
    assign buf_addr_o = beat_idx[3:1];

    // upper half on even beats
    assign wr_half = abeat_q[0] ? bus.wr_word[31:0] : bus.wr_word[63:32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= M_IDLE;
            abeat_q   <= '0;
            hbusreq_o <= 1'b0;
            haddr_o   <= '0;
            htrans_o  <= HTRANS_IDLE;
            hwrite_o  <= 1'b0;
            fin_q     <= 1'b0;
        end else begin
            fin_q <= 1'b0;
            case (state_q)
                M_IDLE: begin
                    if (bus.go) begin
                        hbusreq_o <= 1'b1;
                        hwrite_o  <= bus.wr;
                        haddr_o   <= bus.base_addr;
                        abeat_q   <= '0;
                        state_q   <= M_BUSREQ;
                    end
                end
                M_BUSREQ: begin
                    // ownership moves only when the current transfer completes
                    if (hgrant_i && hready_i) begin
                        htrans_o <= HTRANS_NONSEQ;
                        state_q  <= M_ADDR1;
                    end
                end
                M_ADDR1: begin
                    if (hready_i) begin
                        haddr_o  <= haddr_o + addr_t'(BEAT_BYTES);
                        htrans_o <= HTRANS_SEQ;
                        abeat_q  <= abeat_q + beat_idx_t'(1);
                        state_q  <= M_MIDDLE;
                    end
                end
                M_MIDDLE: begin
                    if (hready_i) begin
                        haddr_o <= haddr_o + addr_t'(BEAT_BYTES);
                        abeat_q <= abeat_q + beat_idx_t'(1);
                        // early release so the arbiter can regrant
                        if (dbeat == beat_idx_t'(BUSREQ_RELEASE_BEAT)) begin
                            hbusreq_o <= 1'b0;
                        end
                        if (abeat_q == beat_idx_t'(BEATS_PER_BURST - 1)) begin
                            htrans_o <= HTRANS_IDLE;
                            state_q  <= M_LAST;
                        end
                    end
                end
                M_LAST: begin
                    if (hready_i) begin
                        fin_q   <= 1'b1;
                        state_q <= M_IDLE;
                    end
                end
                default: begin
                    state_q <= M_IDLE;
                end
            endcase
        end
    end

    // write data for the address being accepted
    always_ff @(posedge clk) begin
        if (hwrite_o && addr_acc) begin
            hwdata_o <= wr_half;
        end
    end

    assign bus.fin      = fin_q;
    assign bus.beat_vld = !hwrite_o && hready_i && data_phase;
    assign bus.beat_idx = beat_idx;
    assign bus.rdata    = hrdata_i;

endmodule

`default_nettype wire

// ==== beat_packer.sv ====
`default_nettype none

module beat_packer
    import comp_engine_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst_n,

    output logic                    comp_wren_o,
    output logic                    comp_sop_o,
    output logic                    comp_eop_o,
    output comp_word_t              comp_wdata_o,

    burst_if.sink                   bus
);

    // 32 beats per block, wraps after the second burst
    logic [4:0] beat_cnt_q;
    logic [3:0] word_idx;

    assign word_idx = beat_cnt_q[4:1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_cnt_q  <= '0;
            comp_wren_o <= 1'b0;
            comp_sop_o  <= 1'b0;
            comp_eop_o  <= 1'b0;
        end else begin
            comp_wren_o <= 1'b0;
            comp_sop_o  <= 1'b0;
            comp_eop_o  <= 1'b0;
            if (bus.beat_vld) begin
                beat_cnt_q <= beat_cnt_q + 5'd1;
                // odd beat completes the word
                if (bus.beat_idx[0]) begin
                    comp_wren_o <= 1'b1;
                    comp_sop_o  <= (word_idx == 4'd0);
                    comp_eop_o  <= (word_idx == 4'hf);
                end
            end
        end
    end

    // ------------------------------
    // word assembly
    // ------------------------------
    always_ff @(posedge clk) begin
        if (bus.beat_vld) begin
            if (bus.beat_idx[0]) begin
                comp_wdata_o[31:0] <= bus.rdata;
            end else begin
                comp_wdata_o[63:32] <= bus.rdata;
            end
        end
    end

endmodule

`default_nettype wire

// ==== comp_engine_top.sv ====
`default_nettype none

module comp_engine_top
    import comp_engine_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst_n,

    // command
    input  wire addr_t              src_addr_i,
    input  wire addr_t              dst_addr_i,
    input  wire blk_cnt_t           len_i,
    input  wire                     start_i,
    output logic                    done_o,

    // AHB master
    output logic                    hbusreq_o,
    input  wire                     hgrant_i,
    output addr_t                   haddr_o,
    output htrans_t                 htrans_o,
    output logic                    hwrite_o,
    output bus_word_t               hwdata_o,
    input  wire bus_word_t          hrdata_i,
    input  wire                     hready_i,

    // compressor stream
    output logic                    comp_wren_o,
    output logic                    comp_sop_o,
    output logic                    comp_eop_o,
    output comp_word_t              comp_wdata_o,
    input  wire [NUM_COMP-1:0]      comp_done_i,
    input  wire [NUM_COMP-1:0]      comp_fail_i,

    // compressor buffers
    output buf_addr_t               buf_addr_o,
    input  wire comp_word_t         comp0_rdata_i,
    input  wire comp_word_t         comp1_rdata_i,
    input  wire comp_word_t         comp2_rdata_i
);

    burst_if i_bus (
        .clk            (clk)
    );

    // ------------------------------
    // block loop and write mux
    // ------------------------------
    blk_sequencer i_blk_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .src_addr_i     (src_addr_i),
        .dst_addr_i     (dst_addr_i),
        .len_i          (len_i),
        .start_i        (start_i),
        .done_o         (done_o),
        .comp_done_i    (comp_done_i),
        .comp_fail_i    (comp_fail_i),
        .comp0_rdata_i  (comp0_rdata_i),
        .comp1_rdata_i  (comp1_rdata_i),
        .comp2_rdata_i  (comp2_rdata_i),
        .bus            (i_bus.seq)
    );

    ahb_burst_master i_ahb_burst_master (
        .clk            (clk),
        .rst_n          (rst_n),
        .hbusreq_o      (hbusreq_o),
        .hgrant_i       (hgrant_i),
        .haddr_o        (haddr_o),
        .htrans_o       (htrans_o),
        .hwrite_o       (hwrite_o),
        .hwdata_o       (hwdata_o),
        .hrdata_i       (hrdata_i),
        .hready_i       (hready_i),
        .buf_addr_o     (buf_addr_o),
        .bus            (i_bus.mst)
    );

    // read beats to 64-bit stream
    beat_packer i_beat_packer (
        .clk            (clk),
        .rst_n          (rst_n),
        .comp_wren_o    (comp_wren_o),
        .comp_sop_o     (comp_sop_o),
        .comp_eop_o     (comp_eop_o),
        .comp_wdata_o   (comp_wdata_o),
        .bus            (i_bus.sink)
    );

endmodule

`default_nettype wire

// ==== comp_engine_checker.sv ====
`default_nettype none

module comp_engine_checker
    import comp_engine_pkg::*;
(
    input wire          clk,
    input wire          rst_n,
    input wire addr_t   haddr_o,
    input wire htrans_t htrans_o,
    input wire          hready_i,
    input wire          comp_wren_o,
    input wire          comp_sop_o,
    input wire          comp_eop_o
);

    // ------------------------------
    // AHB master side
    // ------------------------------
    // beats are HSIZE_WORD wide in an HBURST_INCR16, HPROT_DATA access
    property p_seq_step;
        @(posedge clk) disable iff (!rst_n)
        (htrans_o == HTRANS_SEQ && $past(htrans_o) != HTRANS_IDLE && $past(hready_i))
            |-> (haddr_o == $past(haddr_o) + addr_t'(BEAT_BYTES));
    endproperty

    // wait state freezes the address phase
    property p_hold_on_wait;
        @(posedge clk) disable iff (!rst_n)
        (htrans_o != HTRANS_IDLE && !hready_i)
            |=> (htrans_o == $past(htrans_o) && haddr_o == $past(haddr_o));
    endproperty

    property p_marks_with_wren;
        @(posedge clk) disable iff (!rst_n)
        (comp_sop_o || comp_eop_o) |-> comp_wren_o;
    endproperty

    a_seq_step: assert property (p_seq_step)
        else $error("SEQ address did not step by one beat");
    a_hold_on_wait: assert property (p_hold_on_wait)
        else $error("address phase changed during a wait state");
    a_marks_with_wren: assert property (p_marks_with_wren)
        else $error("sop or eop without write enable");

endmodule

bind comp_engine_top comp_engine_checker i_comp_engine_checker (
    .clk            (clk),
    .rst_n          (rst_n),
    .haddr_o        (haddr_o),
    .htrans_o       (htrans_o),
    .hready_i       (hready_i),
    .comp_wren_o    (comp_wren_o),
    .comp_sop_o     (comp_sop_o),
    .comp_eop_o     (comp_eop_o)
);

`default_nettype wire

// ==== tb_comp_engine.sv ====
`default_nettype none

module tb_comp_engine
    import comp_engine_pkg::*;
();

    localparam int NUM_CMD     = 6;
    localparam int MAX_BLK     = 4;
    localparam int CYC_PER_BLK = 600;
    localparam int PERIOD      = 100;
    localparam int DRV_DLY     = 10;

    logic       clk;
    logic       rst_n;
    addr_t      src_addr;
    addr_t      dst_addr;
    blk_cnt_t   len;
    logic       start;
    logic       done;
    logic       hbusreq;
    logic       hgrant;
    addr_t      haddr;
    htrans_t    htrans;
    logic       hwrite;
    bus_word_t  hwdata;
    bus_word_t  hrdata;
    logic       hready;
    logic       wren;
    logic       sop;
    logic       eop;
    comp_word_t wdata;
    logic [2:0] comp_done;
    logic [2:0] comp_fail;
    buf_addr_t  buf_addr;
    comp_word_t comp0_rdata;
    comp_word_t comp1_rdata;
    comp_word_t comp2_rdata;

    logic [31:0] lfsr_q = 32'h38;
    bus_word_t   mem [addr_t];
    // stream is the same for all three compressors
    comp_word_t  cstream [16];
    comp_word_t  cbuf0 [8];
    comp_word_t  cbuf1 [8];
    comp_word_t  cbuf2 [8];
    logic [2:0]  fail_hist [MAX_BLK];
    logic [3:0]  cdelay [3];
    logic [2:0]  cpend;
    logic [2:0]  cfail_m;
    logic        buf_upd;
    logic        sop_seen;
    // AHB slave data phase
    logic        dph_vld;
    logic        dph_wr;
    addr_t       dph_addr;
    int          dph_idx;
    int          rd_cnt;
    int          wr_cnt;
    int          wdone_cnt;
    int          scnt;
    int          err_cnt;
    logic        obs_done;
    logic        busreq_seen;
    // grant and transfer type of the previous cycle
    logic        grant_q;
    htrans_t     htrans_q;
    int          lens [NUM_CMD];
    int          total_blk;
    time         wd_limit = 0;

    comp_engine_top i_comp_engine_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .src_addr_i     (src_addr),
        .dst_addr_i     (dst_addr),
        .len_i          (len),
        .start_i        (start),
        .done_o         (done),
        .hbusreq_o      (hbusreq),
        .hgrant_i       (hgrant),
        .haddr_o        (haddr),
        .htrans_o       (htrans),
        .hwrite_o       (hwrite),
        .hwdata_o       (hwdata),
        .hrdata_i       (hrdata),
        .hready_i       (hready),
        .comp_wren_o    (wren),
        .comp_sop_o     (sop),
        .comp_eop_o     (eop),
        .comp_wdata_o   (wdata),
        .comp_done_i    (comp_done),
        .comp_fail_i    (comp_fail),
        .buf_addr_o     (buf_addr),
        .comp0_rdata_i  (comp0_rdata),
        .comp1_rdata_i  (comp1_rdata),
        .comp2_rdata_i  (comp2_rdata)
    );

    // buffers are read without latency
    assign comp0_rdata = cbuf0[buf_addr];
    assign comp1_rdata = cbuf1[buf_addr];
    assign comp2_rdata = cbuf2[buf_addr];

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk = ~clk;
        end
    end

    // ------------------------------
    // random source and reference
    // ------------------------------
    function automatic logic next_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic bus_word_t mem_rd(input addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ 32'h5a5a_a5a5;
    endfunction

    function automatic comp_word_t key_of(input int k);
        case (k)
            1: return 64'hfedc_ba98_7654_3210;
            2: return 64'h0f1e_2d3c_4b5a_6978;
            default: return 64'h0123_4567_89ab_cdef;
        endcase
    endfunction

    // word i of a block is memory words 2i and 2i+1
    function automatic comp_word_t ref_word(input int blk, input int i);
        addr_t a;
        a = src_addr + addr_t'(BLK_RD_BYTES * blk + 8 * i);
        return {mem_rd(a), mem_rd(a + 32'd4)};
    endfunction

    function automatic bus_word_t exp_wr(input int blk, input int beat);
        int         win;
        comp_word_t word;
        if (!fail_hist[blk][0]) begin
            win = 0;
        end else if (!fail_hist[blk][1]) begin
            win = 1;
        end else if (!fail_hist[blk][2]) begin
            win = 2;
        end else begin
            win = 0;
        end
        word = ref_word(blk, 2 * (beat / 2)) ^ key_of(win);
        return (beat % 2 == 0) ? word[63:32] : word[31:0];
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "stopping at first error");
        end
    endtask

    // ------------------------------
    // bus and compressor models
    // ------------------------------
    // sampled at the falling edge, where every signal is stable
    task automatic observe();
        int    idx;
        int    blk;
        addr_t exp_a;
        obs_done = done;
        if (hbusreq) begin
            busreq_seen = 1'b1;
        end
        // a burst may open only after a grant with hready high
        if (htrans == HTRANS_NONSEQ && htrans_q == HTRANS_IDLE) begin
            check_value(grant_q, 1, "first address without grant");
        end
        grant_q  = hgrant && hready;
        htrans_q = htrans;
        if (dph_vld && hready) begin
            if (dph_wr) begin
                check_value(hwdata, exp_wr(dph_idx / 16, dph_idx % 16), "write data");
                mem[dph_addr] = hwdata;
                wdone_cnt++;
            end
            dph_vld = 1'b0;
        end
        if (htrans != HTRANS_IDLE && hready) begin
            if (hwrite) begin
                idx   = wr_cnt;
                exp_a = dst_addr + addr_t'(BLK_WR_BYTES * (idx / 16) + 4 * (idx % 16));
                wr_cnt++;
            end else begin
                idx   = rd_cnt;
                exp_a = src_addr + addr_t'(BLK_RD_BYTES * (idx / 32) + 4 * (idx % 32));
                rd_cnt++;
            end
            check_value(haddr, exp_a, "bus address");
            check_value(htrans, (idx % 16 == 0) ? HTRANS_NONSEQ : HTRANS_SEQ, "htrans");
            dph_vld  = 1'b1;
            dph_wr   = hwrite;
            dph_addr = haddr;
            dph_idx  = idx;
        end
        if (wren) begin
            blk = scnt / 16;
            idx = scnt % 16;
            check_value(wdata, ref_word(blk, idx), "stream word");
            check_value(sop, idx == 0, "sop");
            check_value(eop, idx == 15, "eop");
            cstream[idx] = wdata;
            if (sop) begin
                sop_seen = 1'b1;
            end
            if (eop) begin
                for (int k = 0; k < NUM_COMP; k++) begin
                    cdelay[k]  = rand_bits(4);
                    cfail_m[k] = next_bit();
                end
                fail_hist[blk] = cfail_m;
                cpend          = 3'b111;
                buf_upd        = 1'b1;
            end
            scnt++;
        end
    endtask

    task automatic drive_bus();
        hgrant = next_bit();
        hready = next_bit() | next_bit();
        if (dph_vld && !dph_wr) begin
            hrdata = mem_rd(dph_addr);
        end
        if (sop_seen) begin
            comp_done = '0;
            comp_fail = '0;
            sop_seen  = 1'b0;
        end
        if (buf_upd) begin
            for (int j = 0; j < 8; j++) begin
                cbuf0[j] = cstream[2 * j] ^ key_of(0);
                cbuf1[j] = cstream[2 * j] ^ key_of(1);
                cbuf2[j] = cstream[2 * j] ^ key_of(2);
            end
            buf_upd = 1'b0;
        end
        for (int k = 0; k < NUM_COMP; k++) begin
            if (cpend[k]) begin
                if (cdelay[k] == 4'd0) begin
                    comp_done[k] = 1'b1;
                    comp_fail[k] = cfail_m[k];
                    cpend[k]     = 1'b0;
                end else begin
                    cdelay[k] = cdelay[k] - 4'd1;
                end
            end
        end
    endtask

    task automatic step();
        @(negedge clk);
        observe();
        @(posedge clk);
        #DRV_DLY;
        drive_bus();
    endtask

    // ------------------------------
    // commands
    // ------------------------------
    task automatic run_cmd(input int n);
        src_addr = 32'h0010_0000 + (rand_bits(12) << 7);
        dst_addr = 32'h0800_0000 + (rand_bits(12) << 6);
        for (int b = 0; b < n; b++) begin
            for (int i = 0; i < 32; i++) begin
                mem[src_addr + addr_t'(BLK_RD_BYTES * b + 4 * i)] = rand_bits(32);
            end
        end
        rd_cnt      = 0;
        wr_cnt      = 0;
        wdone_cnt   = 0;
        scnt        = 0;
        busreq_seen = 1'b0;
        len         = blk_cnt_t'(n);
        start       = 1'b1;
        step();
        start = 1'b0;
        check_value(obs_done, 0, "done during start");
        if (n == 0) begin
            repeat (6) begin
                step();
                check_value(obs_done, 1, "done with zero length");
            end
            check_value(busreq_seen, 0, "bus request with zero length");
        end else begin
            while (!obs_done) begin
                step();
            end
            check_value(wdone_cnt, 16 * n, "write beats at done");
            check_value(rd_cnt, 32 * n, "read beats at done");
            check_value(scnt, 16 * n, "stream words at done");
            check_value(hbusreq, 0, "bus request at done");
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        len       = '0;
        src_addr  = '0;
        dst_addr  = '0;
        hgrant    = 1'b0;
        hready    = 1'b1;
        hrdata    = '0;
        comp_done = '0;
        comp_fail = '0;
        cpend     = '0;
        cfail_m   = '0;
        buf_upd   = 1'b0;
        sop_seen  = 1'b0;
        dph_vld   = 1'b0;
        dph_wr    = 1'b0;
        dph_addr  = '0;
        dph_idx   = 0;
        err_cnt   = 0;
        obs_done  = 1'b0;
        grant_q   = 1'b0;
        htrans_q  = HTRANS_IDLE;
        for (int j = 0; j < 8; j++) begin
            cbuf0[j] = '0;
            cbuf1[j] = '0;
            cbuf2[j] = '0;
        end
        // first command always has zero length
        lens[0]   = 0;
        total_blk = 0;
        for (int c = 1; c < NUM_CMD; c++) begin
            lens[c]   = rand_bits(3) % 5;
            total_blk = total_blk + lens[c];
        end
        wd_limit = (total_blk * CYC_PER_BLK + NUM_CMD * 50 + 20) * PERIOD;
        repeat (2) @(posedge clk);
        #DRV_DLY;
        rst_n = 1'b1;
        step();
        check_value(obs_done, 1, "done after reset");
        for (int c = 0; c < NUM_CMD; c++) begin
            run_cmd(lens[c]);
        end
        repeat (4) step();
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        wait (wd_limit != 0);
        #(wd_limit);
        $display("Timeout: engine did not finish all commands in time");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
comp_engine_pkg.sv
burst_if.sv
blk_sequencer.sv
ahb_burst_master.sv
beat_packer.sv
comp_engine_top.sv
comp_engine_checker.sv
tb_comp_engine.sv
